/* Makefile */
# Verilator build and run of the system bus testbench

VERILATOR ?= verilator
TOP       ?= soc_bus_tb
FILELIST  ?= soc_bus.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean build

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run, fails unless the pass line appears"
	@echo "  clean  remove $(OBJ_DIR)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

test: build
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx '\*\* PASS \*\*'

clean:
	rm -rf $(OBJ_DIR)

/* logic/addr_decode.sv */
/*
 * Request stage of the system bus
 * Samples one master cycle when idle, classifies it by space and
 * address window, then issues it to one slave port with a tag
 */

`timescale 1ns/1ps
`default_nettype none

module addr_decode import soc_bus_pkg::*; (
  input  wire logic      clk,
  input  wire logic      rst_lck,
  input  wire logic      cyc_i,
  input  wire logic      stb_i,
  input  wire logic      we_i,
  input  wire logic      io_i,     // I/O space flag
  input  wire word_adr_t adr_i,
  input  wire sel_t      sel_i,
  input  wire data_t     dat_i,
  input  wire logic      inta_i,
  input  wire logic      ack_i,    // Outer acknowledge, ends busy
  bus_if.master          ram_o,
  bus_if.master          gpio_o,
  output req_tag_t       tag_o
);

  logic      busy_q;
  logic      sample;
  logic      valid_q;     // Sampled this cycle
  target_e   tgt_d, tgt_q;
  logic      we_q;
  word_adr_t adr_q;
  sel_t      sel_q;
  data_t     dat_q;
  logic      ram_stb_q, gpio_stb_q;

  assign sample = cyc_i && stb_i && !busy_q;

  // Priority order, interrupt acknowledge first
  always_comb begin
    if (inta_i)
      tgt_d = TGT_VECTOR;
    else if (io_i == RAM_SPACE)
      tgt_d = TGT_RAM;
    else if ((adr_i & GPIO_MASK) == GPIO_BASE)
      tgt_d = TGT_GPIO;
    else
      tgt_d = TGT_NONE;
  end

  always_ff @(posedge clk) begin
    if (!rst_lck) begin
      busy_q     <= 1'b0;
      valid_q    <= 1'b0;
      ram_stb_q  <= 1'b0;
      gpio_stb_q <= 1'b0;
      tag_o      <= '{issue: 1'b0, tgt: TGT_NONE};
    end else begin
      if (sample)
        busy_q <= 1'b1;
      else if (ack_i)
        busy_q <= 1'b0;  // Free again after the ack cycle
      valid_q    <= sample;
      ram_stb_q  <= valid_q && (tgt_q == TGT_RAM);
      gpio_stb_q <= valid_q && (tgt_q == TGT_GPIO);
      tag_o      <= '{issue: valid_q, tgt: tgt_q};
    end
  end

  // Request fields, stable until the next sample
  always_ff @(posedge clk) begin
    if (sample) begin
      tgt_q <= tgt_d;
      we_q  <= we_i;
      adr_q <= adr_i;
      sel_q <= sel_i;
      dat_q <= dat_i;
    end
  end

  assign ram_o.stb   = ram_stb_q;
  assign ram_o.we    = we_q;
  assign ram_o.adr   = adr_q;
  assign ram_o.sel   = sel_q;
  assign ram_o.wdat  = dat_q;

  assign gpio_o.stb  = gpio_stb_q;
  assign gpio_o.we   = we_q;
  assign gpio_o.adr  = adr_q;
  assign gpio_o.sel  = sel_q;
  assign gpio_o.wdat = dat_q;

endmodule

`default_nettype wire

/* logic/bus_if.sv */
/*
 * Slave port of the system bus
 * Request from the decode stage, response from one slave,
 * and a monitor view for the response stage
 */

`timescale 1ns/1ps
`default_nettype none

interface bus_if import soc_bus_pkg::*; ();

  logic      stb;   // Single-cycle issue pulse
  logic      we;
  word_adr_t adr;
  sel_t      sel;
  data_t     wdat;
  logic      ack;   // One cycle, the edge after stb
  data_t     rdat;  // Valid with ack

  modport master (output stb, we, adr, sel, wdat, input ack, rdat);

  modport slave (input stb, we, adr, sel, wdat, output ack, rdat);

  modport monitor (input stb, we, adr, sel, wdat, ack, rdat);

endinterface

`default_nettype wire

/* logic/gpio_regs.sv */
/*
 * Switch and LED register slave
 * Word 0 reads the switches, word 1 is the LED register
 * with read-back
 */

`timescale 1ns/1ps
`default_nettype none

module gpio_regs import soc_bus_pkg::*; (
  input  wire logic       clk,
  input  wire logic       rst_lck,
  bus_if.slave            bus,
  input  wire logic [7:0] sw_i,
  output logic      [7:0] leds_o
);

  logic       ack_q;
  data_t      rdat_q;
  logic [7:0] leds_q;
  logic       led_wr;

  // Word offset 1, low lane only
  assign led_wr = bus.stb && bus.we && bus.adr[0] && bus.sel[0];

  always_ff @(posedge clk) begin
    if (!rst_lck) begin
      ack_q  <= 1'b0;
      leds_q <= 8'h00;
    end else begin
      ack_q <= bus.stb;
      if (led_wr)
        leds_q <= bus.wdat[7:0];
    end
  end

  always_ff @(posedge clk) begin
    if (bus.stb)
      rdat_q <= bus.adr[0] ? {8'h00, leds_q} : {8'h00, sw_i};
  end

  assign bus.ack  = ack_q;
  assign bus.rdat = rdat_q;
  assign leds_o   = leds_q;

endmodule

`default_nettype wire

/* logic/resp_mux.sv */
/*
 * Response stage of the system bus
 * Default responder and interrupt vector, then the steering mux
 * to the registered outer data and acknowledge
 */

`timescale 1ns/1ps
`default_nettype none

module resp_mux import soc_bus_pkg::*; (
  input  wire logic       clk,
  input  wire logic       rst_lck,
  input  wire req_tag_t   tag_i,
  input  wire logic [2:0] iid_i,   // Held by the master during inta
  bus_if.monitor          ram_i,
  bus_if.monitor          gpio_i,
  output data_t           dat_o,
  output logic            ack_o
);

  req_tag_t hold_q;   // Target of the cycle in flight
  data_t    own_q;    // Local answer for NONE and VECTOR
  logic     ack_d;
  data_t    dat_d;

  always_ff @(posedge clk) begin
    if (!rst_lck)
      hold_q <= '{issue: 1'b0, tgt: TGT_NONE};
    else if (tag_i.issue)
      hold_q <= tag_i;
    else
      hold_q.issue <= 1'b0;  // Keep the target, drop the pulse
  end

  always_ff @(posedge clk) begin
    if (tag_i.issue)
      own_q <= (tag_i.tgt == TGT_VECTOR) ? VEC_BASE + data_t'(iid_i) : '0;
  end

  // Steer by the held target
  always_comb begin
    case (hold_q.tgt)
      TGT_RAM: begin
        ack_d = ram_i.ack;
        dat_d = ram_i.rdat;
      end
      TGT_GPIO: begin
        ack_d = gpio_i.ack;
        dat_d = gpio_i.rdat;
      end
      default: begin
        ack_d = hold_q.issue;
        dat_d = own_q;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_lck)
      ack_o <= 1'b0;
    else
      ack_o <= ack_d;
  end

  always_ff @(posedge clk) begin
    if (ack_d)
      dat_o <= dat_d;
  end

endmodule

`default_nettype wire

/* logic/soc_bus.sv */
/*
 * System bus core top level
 * Request stage, RAM and GPIO slaves, response stage
 */

`timescale 1ns/1ps
`default_nettype none

module soc_bus import soc_bus_pkg::*; #(
  parameter int RAM_AW = 10  // RAM depth in words, log2
) (
  input  wire logic       clk,
  input  wire logic       rst_lck,

  // Master side, held until ack_o
  input  wire logic       cyc_i,
  input  wire logic       stb_i,
  input  wire logic       we_i,
  input  wire logic       io_i,
  input  wire word_adr_t  adr_i,
  input  wire sel_t       sel_i,
  input  wire data_t      dat_i,
  input  wire logic       inta_i,
  input  wire logic [2:0] iid_i,
  output data_t           dat_o,
  output logic            ack_o,

  // Board I/O
  input  wire logic [7:0] sw_i,
  output logic      [7:0] leds_o
);

  req_tag_t tag;

  bus_if ram_bus ();
  bus_if gpio_bus ();

  addr_decode u_decode (
    .clk     (clk),
    .rst_lck (rst_lck),
    .cyc_i   (cyc_i),
    .stb_i   (stb_i),
    .we_i    (we_i),
    .io_i    (io_i),
    .adr_i   (adr_i),
    .sel_i   (sel_i),
    .dat_i   (dat_i),
    .inta_i  (inta_i),
    .ack_i   (ack_o),
    .ram_o   (ram_bus.master),
    .gpio_o  (gpio_bus.master),
    .tag_o   (tag)
  );

  sys_ram #(
    .RAM_AW (RAM_AW)
  ) u_ram (
    .clk (clk),
    .bus (ram_bus.slave)
  );

  gpio_regs u_gpio (
    .clk     (clk),
    .rst_lck (rst_lck),
    .bus     (gpio_bus.slave),
    .sw_i    (sw_i),
    .leds_o  (leds_o)
  );

  resp_mux u_resp (
    .clk     (clk),
    .rst_lck (rst_lck),
    .tag_i   (tag),
    .iid_i   (iid_i),
    .ram_i   (ram_bus.monitor),
    .gpio_i  (gpio_bus.monitor),
    .dat_o   (dat_o),
    .ack_o   (ack_o)
  );

endmodule

`default_nettype wire

/* logic/soc_bus_pkg.sv */
/*
 * Shared definitions for the system bus core
 * Bus widths and word types, GPIO decode window, memory-space rule,
 * interrupt vector base, target encoding and the request tag
 */

`default_nettype none

package soc_bus_pkg;

  localparam int DATA_W = 16;
  localparam int ADR_W  = 19;  // Word address, byte address bits 19..1

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [ADR_W-1:0]  word_adr_t;
  typedef logic [1:0]        sel_t;     // Byte lanes, bit 1 is the high byte

  // GPIO block at io 0xf100 - 0xf103, two words
  localparam word_adr_t GPIO_BASE = 19'h07880;
  localparam word_adr_t GPIO_MASK = 19'h07ffe;

  // I/O flag value of a memory cycle, all of memory is RAM
  localparam logic RAM_SPACE = 1'b0;

  // Interrupt vector base, the id is added on top
  localparam data_t VEC_BASE = 16'h0008;

  // Where a cycle is steered
  typedef enum logic [1:0] {
    TGT_RAM    = 2'd0,
    TGT_GPIO   = 2'd1,
    TGT_NONE   = 2'd2,  // Default responder, reads zero
    TGT_VECTOR = 2'd3   // Interrupt acknowledge
  } target_e;

  // Request stage to response stage
  typedef struct packed {
    logic    issue;  // One-cycle pulse with the slave stb
    target_e tgt;
  } req_tag_t;

endpackage

`default_nettype wire

/* logic/sys_ram.sv */
/*
 * Base memory slave
 * Word RAM of 2**RAM_AW words with byte-lane writes,
 * higher address bits alias
 */

`timescale 1ns/1ps
`default_nettype none

module sys_ram import soc_bus_pkg::*; #(
  parameter int RAM_AW = 10
) (
  input wire logic clk,
  bus_if.slave     bus
);

  data_t             mem [2**RAM_AW];
  logic [RAM_AW-1:0] idx;
  logic              ack_q;
  data_t             rdat_q;

  assign idx = bus.adr[RAM_AW-1:0];  // Low word bits only

  always_ff @(posedge clk) begin
    if (bus.stb && bus.we) begin
      if (bus.sel[0])
        mem[idx][7:0] <= bus.wdat[7:0];
      if (bus.sel[1])
        mem[idx][15:8] <= bus.wdat[15:8];
    end
  end

  // Answer the edge after the issue
  always_ff @(posedge clk) begin
    ack_q <= bus.stb;
    if (bus.stb)
      rdat_q <= mem[idx];
  end

  assign bus.ack  = ack_q;
  assign bus.rdat = rdat_q;

endmodule

`default_nettype wire

/* soc_bus.f */
logic/soc_bus_pkg.sv
logic/bus_if.sv
logic/addr_decode.sv
logic/sys_ram.sv
logic/gpio_regs.sv
logic/resp_mux.sv
logic/soc_bus.sv
verification/soc_bus_asserts.sv
verification/soc_bus_checker.sv
verification/soc_bus_tb.sv

/* verification/soc_bus_asserts.sv */
/*
 * Concurrent checks on the outer bus handshake
 * Single-cycle ack, fixed three-cycle latency, quiet ack in reset,
 * and a count of failed checks
 */

`timescale 1ns/1ps
`default_nettype none

module soc_bus_asserts (
  input wire logic clk,
  input wire logic rst_lck,
  input wire logic cyc_i,
  input wire logic stb_i,
  input wire logic ack_i
);

  logic busy_q;
  logic sampled;
  int   fail_cnt;  // Failed assertions so far

  assign sampled = cyc_i && stb_i && !busy_q;  // Request taken on this edge

  always @(posedge clk) begin
    if (!rst_lck)
      busy_q <= 1'b0;
    else if (sampled)
      busy_q <= 1'b1;
    else if (ack_i)
      busy_q <= 1'b0;
  end

  ack_single: assert property (@(posedge clk) disable iff (!rst_lck) ack_i |=> !ack_i)
    else begin
      $error("ack_o high for more than one cycle");
      fail_cnt++;
    end

  ack_latency: assert property (@(posedge clk) disable iff (!rst_lck)
    sampled |-> ##1 !ack_i ##1 !ack_i ##1 !ack_i ##1 ack_i)
    else begin
      $error("ack_o not three cycles after the sampled request");
      fail_cnt++;
    end

  ack_in_reset: assert property (@(posedge clk) !rst_lck |=> !ack_i)
    else begin
      $error("ack_o high during reset");
      fail_cnt++;
    end

endmodule

`default_nettype wire

/* verification/soc_bus_checker.sv */
/*
 * Bus monitor with a reference model
 * Sparse RAM and LED models, expected read data,
 * latency and spurious ack checks on the outer bus
 */

`timescale 1ns/1ps
`default_nettype none

module soc_bus_checker import soc_bus_pkg::*; #(
  parameter int RAM_AW = 10
) (
  input  wire logic       clk,
  input  wire logic       rst_lck,
  input  wire logic       cyc_i,
  input  wire logic       stb_i,
  input  wire logic       we_i,
  input  wire logic       io_i,
  input  wire word_adr_t  adr_i,
  input  wire sel_t       sel_i,
  input  wire data_t      dat_i,
  input  wire logic       inta_i,
  input  wire logic [2:0] iid_i,
  input  wire logic [7:0] sw_i,
  input  wire data_t      dat_o,
  input  wire logic       ack_o,
  input  wire logic [7:0] leds_o,
  output int              err_cnt,
  output int              ack_cnt
);

  data_t      ram_val [int];
  logic [1:0] ram_known [int];  // Lanes written so far
  logic [7:0] led_mdl;
  logic       busy;
  int         lat;
  data_t      exp_dat, exp_mask;

  // Expected read data, mask marks the bits worth comparing
  function automatic data_t ref_cycle(input logic w, input logic space, input word_adr_t a,
                                      input sel_t s, input data_t d, input logic ia,
                                      input logic [2:0] id, input logic [7:0] sw,
                                      output data_t mask);
    int         key;
    data_t      v;
    logic [1:0] k;
    key  = int'(a) & ((1 << RAM_AW) - 1);  // High word bits alias
    mask = w ? 16'h0000 : 16'hffff;
    if (ia)
      return VEC_BASE + {13'b0, id};
    if (!space) begin
      v = ram_val.exists(key) ? ram_val[key] : 16'h0000;
      k = ram_known.exists(key) ? ram_known[key] : 2'b00;
      if (w) begin
        if (s[0]) v[7:0] = d[7:0];
        if (s[1]) v[15:8] = d[15:8];
        ram_val[key]   = v;
        ram_known[key] = k | s;
      end
      mask = mask & {{8{k[1]}}, {8{k[0]}}};
      return v;
    end
    if ((a >> 1) == 19'h03c40) begin  // Ports 0xf100 to 0xf103
      if (a[0] && w && s[0])
        led_mdl = d[7:0];
      return a[0] ? {8'h00, led_mdl} : {8'h00, sw};
    end
    return 16'h0000;  // Default responder
  endfunction

  initial begin
    err_cnt = 0;
    ack_cnt = 0;
  end

  always @(negedge clk) begin
    if (!rst_lck) begin
      busy    = 1'b0;
      led_mdl = 8'h00;
    end else if (busy) begin
      lat++;
      if (ack_o) begin
        busy = 1'b0;
        ack_cnt++;
        if (lat != 4) begin
          $display("[ERROR] %0t: ack %0d cycles after sampling, expected 3", $time, lat - 1);
          err_cnt++;
        end
        if ((dat_o & exp_mask) !== (exp_dat & exp_mask)) begin
          $display("[ERROR] %0t: dat_o expected %04h got %04h", $time, exp_dat, dat_o);
          err_cnt++;
        end
        if (leds_o !== led_mdl) begin
          $display("[ERROR] %0t: leds_o expected %02h got %02h", $time, led_mdl, leds_o);
          err_cnt++;
        end
      end
    end else if (ack_o) begin
      $display("[ERROR] %0t: ack_o raised with no request in flight", $time);
      err_cnt++;
    end else if (cyc_i && stb_i) begin
      exp_dat = ref_cycle(we_i, io_i, adr_i, sel_i, dat_i, inta_i, iid_i, sw_i, exp_mask);
      busy    = 1'b1;
      lat     = 0;
    end
  end

endmodule

`default_nettype wire

/* verification/soc_bus_tb.sv */
/*
 * Testbench for the system bus core
 * Clock, reset, bus read/write/inta tasks, test sequence,
 * cycle limit and the closing summary
 */

`timescale 1ns/1ps
`default_nettype none

module soc_bus_tb import soc_bus_pkg::*; ();

  localparam int RAM_AW = 10;
  localparam int NUM_TX = 2 * 200 + 8 + 4 + 8 + 6;  // ram, gpio, unmapped, inta, mixed
  localparam int LIMIT  = NUM_TX * 40 + 10;

  logic       clk, rst_lck, cyc, stb, we, io, inta, ack;
  word_adr_t  adr;
  sel_t       sel;
  data_t      dat, rdat;
  logic [2:0] iid;
  logic [7:0] sw, leds;
  int         err_cnt, ack_cnt, tx_cnt, fails, tests, cycles;
  int         err_mark, ack_mark, tx_mark;
  word_adr_t  adrs [200];

  soc_bus #(.RAM_AW(RAM_AW)) dut_i (
    .clk(clk), .rst_lck(rst_lck), .cyc_i(cyc), .stb_i(stb), .we_i(we), .io_i(io),
    .adr_i(adr), .sel_i(sel), .dat_i(dat), .inta_i(inta), .iid_i(iid),
    .dat_o(rdat), .ack_o(ack), .sw_i(sw), .leds_o(leds)
  );

  soc_bus_checker #(.RAM_AW(RAM_AW)) chk_i (
    .clk(clk), .rst_lck(rst_lck), .cyc_i(cyc), .stb_i(stb), .we_i(we), .io_i(io),
    .adr_i(adr), .sel_i(sel), .dat_i(dat), .inta_i(inta), .iid_i(iid), .sw_i(sw),
    .dat_o(rdat), .ack_o(ack), .leds_o(leds), .err_cnt(err_cnt), .ack_cnt(ack_cnt)
  );

  bind soc_bus soc_bus_asserts asrt_i (
    .clk(clk), .rst_lck(rst_lck), .cyc_i(cyc_i), .stb_i(stb_i), .ack_i(ack_o)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= LIMIT) begin
      $display("Timeout: the run did not finish within %0d clock cycles", LIMIT);
      $display("** FAIL **");
      $finish;
    end
  end

  // Hold the request until ack, then one idle cycle
  task automatic bus_cycle(input logic w, input logic space, input word_adr_t a,
                           input sel_t s, input data_t d, input logic ia, input logic [2:0] id);
    cyc  = 1'b1;
    stb  = 1'b1;
    we   = w;
    io   = space;
    adr  = a;
    sel  = s;
    dat  = d;
    inta = ia;
    iid  = id;
    @(negedge clk);
    while (!ack) @(negedge clk);
    @(posedge clk);
    #2 cyc = 1'b0;
    stb  = 1'b0;
    inta = 1'b0;
    tx_cnt++;
    @(posedge clk);
    #2;
  endtask

  task automatic bus_write(input logic space, input word_adr_t a, input sel_t s, input data_t d);
    bus_cycle(1'b1, space, a, s, d, 1'b0, 3'd0);
  endtask

  task automatic bus_read(input logic space, input word_adr_t a);
    bus_cycle(1'b0, space, a, 2'b11, 16'h0000, 1'b0, 3'd0);
  endtask

  task automatic int_ack(input logic [2:0] id);
    bus_cycle(1'b0, 1'b1, '0, 2'b11, 16'h0000, 1'b1, id);
  endtask

  task automatic start_test();
    err_mark = err_cnt;
    ack_mark = ack_cnt;
    tx_mark  = tx_cnt;
  endtask

  task automatic report_test(input string name);
    int errs;
    int acks;
    errs = err_cnt - err_mark;
    acks = ack_cnt - ack_mark;
    tests++;
    if (errs == 0 && acks == tx_cnt - tx_mark) begin
      $display("test %-12s ok, %0d cycles acknowledged", name, acks);
    end else begin
      fails++;
      $display("test %-12s failed, %0d errors, %0d of %0d acks", name, errs, acks,
               tx_cnt - tx_mark);
    end
  endtask

  initial begin
    void'($urandom(32'h6966));
    clk     = 1'b0;
    rst_lck = 1'b0;
    cyc     = 1'b0;
    stb     = 1'b0;
    we      = 1'b0;
    io      = 1'b0;
    adr     = '0;
    sel     = '0;
    dat     = '0;
    inta    = 1'b0;
    iid     = '0;
    sw      = 8'ha5;
    repeat (10) @(posedge clk);
    #2 rst_lck = 1'b1;

    start_test();
    for (int i = 0; i < 200; i++) begin
      adrs[i] = word_adr_t'($urandom);
      if (i % 5 == 4)
        adrs[i] = adrs[i-1] + (word_adr_t'(1) << RAM_AW);  // Alias of the previous word
      bus_write(1'b0, adrs[i], sel_t'($urandom_range(0, 3)), data_t'($urandom));
    end
    for (int i = 0; i < 200; i++)
      bus_read(1'b0, adrs[i]);
    report_test("ram");

    start_test();
    bus_read(1'b1, 19'h07880);
    bus_write(1'b1, 19'h07881, 2'b01, 16'h123c);
    bus_read(1'b1, 19'h07881);
    bus_write(1'b1, 19'h07881, 2'b10, 16'hff00);  // High lane only, no effect
    bus_write(1'b1, 19'h07880, 2'b11, 16'hffff);
    bus_read(1'b1, 19'h07880);
    bus_read(1'b1, 19'h07881);
    sw = 8'h5a;
    bus_read(1'b1, 19'h07880);
    report_test("gpio");

    start_test();
    bus_read(1'b1, 19'h001fc);  // Port 0x3f8
    bus_read(1'b1, 19'h00030);  // Port 0x60
    bus_write(1'b1, 19'h001fc, 2'b11, 16'hbeef);
    bus_read(1'b1, 19'h07882);
    report_test("unmapped_io");

    start_test();
    for (int i = 0; i < 8; i++)
      int_ack(3'(i));
    report_test("inta");

    start_test();
    bus_write(1'b0, 19'h00123, 2'b11, 16'hc0de);
    bus_read(1'b1, 19'h07881);
    bus_read(1'b0, 19'h00123);
    int_ack(3'd5);
    bus_read(1'b1, 19'h00030);
    bus_read(1'b0, 19'h40123);
    report_test("back_to_back");

    $display("%0d tests, %0d failed, %0d errors, %0d assertion failures, %0d cycles",
             tests, fails, err_cnt, dut_i.asrt_i.fail_cnt, tx_cnt);
    if (fails == 0 && err_cnt == 0 && dut_i.asrt_i.fail_cnt == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

`default_nettype wire
